// File: Makefile
VERILATOR ?= verilator
TOP       := main_bus_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/wb_host_tasks.svh
// wishbone master side of the testbench; expects clk and the bus signals declared before inclusion
`ifndef wb_host_tasks_svh
`define wb_host_tasks_svh

localparam int ack_timeout_cycles = 64;

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected)
        abort_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
endtask

// put a new cycle on the bus, byte address in
task automatic wb_start(input logic is_write, input logic [23:0] byte_addr,
                        input logic [15:0] wdata);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= is_write;
    adr   <= byte_addr[23:1];
    dat_w <= wdata;
    sel   <= 2'b11;
endtask

// sampled on the falling edge, released on the next rising one
task automatic wb_wait_ack(input string name, output logic [15:0] data, output int cycles);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!ack && waited < ack_timeout_cycles) begin
        @(negedge clk);
        waited++;
    end
    if (!ack)
        abort_run({"no acknowledge from the DUT for cycle ", name});
    data   = dat_r;
    cycles = waited;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
endtask

task automatic wb_write(input string name, input logic [23:0] byte_addr,
                        input logic [15:0] wdata, output int cycles);
    logic [15:0] unused;
    wb_start(1'b1, byte_addr, wdata);
    wb_wait_ack(name, unused, cycles);
endtask

task automatic wb_read(input string name, input logic [23:0] byte_addr,
                       output logic [15:0] data, output int cycles);
    wb_start(1'b0, byte_addr, 16'h0000);
    wb_wait_ack(name, data, cycles);
endtask

`endif

// File: dv/main_bus_tb.sv
// testbench for main_bus_top; memory model answers within 0 to 3 cycles, full 16-bit cycles only
`timescale 1ns/1ps

module main_bus_tb;
    import arcade_bus_pkg::*;
    import arcade_io_pkg::*;

    logic        clk          = 1'b0;
    logic        rst          = 1'b1;
    logic        cyc          = 1'b0;
    logic        stb          = 1'b0;
    logic        we           = 1'b0;
    logic [22:0] adr          = '0;
    logic [15:0] dat_w        = '0;
    logic [1:0]  sel          = '0;
    logic        lvbl         = 1'b1;
    logic        lhbl         = 1'b1;
    logic        mcu_req      = 1'b0;
    logic [15:0] mcu_dout     = 16'h1234;
    logic [7:0]  joystick1    = 8'h3c;
    logic [7:0]  joystick2    = 8'hc5;
    logic [1:0]  start_button = 2'b10;
    logic [1:0]  coin_input   = 2'b01;
    logic        service      = 1'b1;
    logic [7:0]  dipsw_a      = 8'h7e;
    logic [7:0]  dipsw_b      = 8'h81;
    logic [15:0] mem_dout     = '0;
    logic        mem_ok       = 1'b0;
    logic [15:0] dat_r;
    logic        ack;
    logic [15:0] mcu_din;
    logic        mcu_wr;
    logic [7:0]  snd_latch;
    logic        snd_irq;
    logic [2:0]  prisel;
    logic        mem_cs;
    mem_region_e mem_region;
    logic [12:0] mem_addr;
    logic [2:0]  irq_level;

    mem_region_e expected_region = region_none;   // what the model accepts on mem_cs
    int          mem_delay       = 0;
    logic        mem_busy        = 1'b0;
    int          snd_irq_pulses  = 0;
    int          mcu_wr_pulses   = 0;
    mem_region_e disp_regions[3] = '{region_disp_f, region_disp_b, region_disp_c};

    // stimulus table
    string       tbl_name[$];
    logic        tbl_we[$];
    logic [23:0] tbl_addr[$];
    logic [15:0] tbl_wdata[$];
    logic [15:0] tbl_rdata[$];
    mem_region_e tbl_region[$];

    `include "wb_host_tasks.svh"

    main_bus_top dut (.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] mem_pattern(input logic [2:0] region, input logic [12:0] off);
        return {region, off} ^ 16'h5a3c;
    endfunction

    function automatic logic [23:0] io_addr(input logic [3:0] off);
        return io_base + {off, 1'b0};
    endfunction

    // memory port model with random latency
    always @(posedge clk) begin
        if (rst) begin
            mem_ok   <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            mem_ok <= 1'b0;
            if (mem_cs && !mem_ok) begin
                if (!mem_busy) begin
                    check_value("memory region", 16'(expected_region), 16'(mem_region));
                    mem_delay = int'($urandom % 4);
                    mem_busy  = 1'b1;
                end
                if (mem_delay == 0) begin
                    mem_ok   <= 1'b1;
                    mem_dout <= mem_pattern(mem_region, mem_addr);
                    mem_busy = 1'b0;
                end else begin
                    mem_delay = mem_delay - 1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && snd_irq)
            snd_irq_pulses++;
        if (!rst && mcu_wr)
            mcu_wr_pulses++;
    end

    task automatic add_entry(input string name, input logic is_write, input logic [23:0] addr,
                             input logic [15:0] wdata, input logic [15:0] rdata,
                             input mem_region_e region);
        tbl_name.push_back(name);
        tbl_we.push_back(is_write);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_rdata.push_back(rdata);
        tbl_region.push_back(region);
    endtask

    task automatic add_mem_read(input string name, input mem_region_e region,
                                input logic [23:0] addr);
        add_entry(name, 1'b0, addr, 16'h0000, mem_pattern(region, addr[13:1]), region);
    endtask

    task automatic build_table();
        add_entry("cab0 read", 1'b0, io_addr(reg_cab0), 16'h0000, 16'hc53c, region_none);
        // ff, blank off, service, coin 01, start 10, 11
        add_entry("cab1 read", 1'b0, io_addr(reg_cab1), 16'h0000, 16'hff5b, region_none);
        add_entry("dip read", 1'b0, io_addr(reg_dip), 16'h0000, 16'h817e, region_none);
        add_entry("sound write", 1'b1, io_addr(reg_snd), 16'h7e5a, 16'h0000, region_none);
        add_entry("mcu write", 1'b1, io_addr(reg_mcu_wr), 16'hb00f, 16'h0000, region_none);
        add_entry("mcu read", 1'b0, io_addr(reg_mcu_rd), 16'h0000, 16'h1234, region_none);
        add_entry("prisel write", 1'b1, io_addr(reg_prisel), 16'h0005, 16'h0000, region_none);
        add_mem_read("sysram read", region_sysram, 24'h319a46);
        add_mem_read("pal0 read", region_pal0, 24'h3102f0);
        add_mem_read("pal1 read", region_pal1, 24'h317ffe);
        add_mem_read("sysram base read", region_sysram, sysram_base);
        // unmapped and wrong-direction cycles
        add_entry("write-only offset read", 1'b0, io_addr(reg_snd), 16'h0000, 16'hffff,
                  region_none);
        add_entry("unused read slot", 1'b0, io_addr(4'd3), 16'h0000, 16'hffff, region_none);
        add_entry("unmapped read", 1'b0, 24'h200000, 16'h0000, 16'hffff, region_none);
        add_entry("unmapped write", 1'b1, 24'h200014, 16'h00a1, 16'h0000, region_none);
        add_entry("read-only offset write", 1'b1, io_addr(reg_dip), 16'h00c3, 16'h0000,
                  region_none);
    endtask

    task automatic wait_irq_level(input string name, input logic [2:0] level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (irq_level !== level && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (irq_level !== level)
            abort_run({"interrupt level never reached for ", name});
    endtask

    initial begin
        int unsigned seed;
        logic [15:0] rdata;
        logic [23:0] addr;
        int          lat;

        seed = $urandom(32'h855d);
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < tbl_name.size(); i++) begin
            expected_region = tbl_region[i];
            if (tbl_we[i]) begin
                wb_write(tbl_name[i], tbl_addr[i], tbl_wdata[i], lat);
            end else begin
                wb_read(tbl_name[i], tbl_addr[i], rdata, lat);
                check_value(tbl_name[i], tbl_rdata[i], rdata);
            end
            if (tbl_region[i] == region_none)   // register and unmapped cycles
                check_value({tbl_name[i], " latency"}, 16'd1, 16'(lat));
        end

        // outputs after the table, unmapped writes must not have touched them
        @(negedge clk);
        check_value("snd_latch", 16'h005a, {8'h00, snd_latch});
        check_value("mcu_din", 16'hb00f, mcu_din);
        check_value("prisel", 16'h0005, {13'h0000, prisel});
        check_value("snd_irq pulses", 16'd1, 16'(snd_irq_pulses));
        check_value("mcu_wr pulses", 16'd1, 16'(mcu_wr_pulses));

        // interrupt priority
        expected_region = region_none;
        check_value("irq idle", 16'(irq_lvl_none), 16'(irq_level));
        @(posedge clk);
        lvbl <= 1'b0;
        wait_irq_level("vblank", irq_lvl_vblank);
        @(posedge clk);
        lvbl    <= 1'b1;
        mcu_req <= 1'b1;
        repeat (3) @(negedge clk);
        check_value("vblank over mcu", 16'(irq_lvl_vblank), 16'(irq_level));
        wb_write("vint clear", io_addr(reg_vint_clr), 16'h0000, lat);
        @(negedge clk);
        check_value("irq after vint clear", 16'(irq_lvl_mcu), 16'(irq_level));
        wb_read("mcu ack read", io_addr(reg_mcu_rd), rdata, lat);
        check_value("mcu ack read data", 16'h1234, rdata);
        @(negedge clk);
        check_value("irq after mcu ack", 16'(irq_lvl_none), 16'(irq_level));
        @(posedge clk);
        mcu_req <= 1'b0;

        // display hold-off, one read per layer
        for (int k = 0; k < 3; k++) begin
            addr = disp_base + 24'(k) * disp_layer_size + 24'h0a5e;
            expected_region = disp_regions[k];
            wb_start(1'b0, addr, 16'h0000);
            repeat (20) begin
                @(negedge clk);
                check_value($sformatf("layer %0d hold ack", k), 16'h0000, {15'h0000, ack});
                check_value($sformatf("layer %0d hold mem_cs", k), 16'h0000, {15'h0000, mem_cs});
            end
            @(posedge clk);
            lhbl <= 1'b0;   // hblank opens the gate
            wb_wait_ack($sformatf("layer %0d read", k), rdata, lat);
            check_value($sformatf("layer %0d data", k), mem_pattern(disp_regions[k], addr[13:1]),
                        rdata);
            @(posedge clk);
            lhbl <= 1'b1;
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: hdl/arcade_bus_pkg.sv
// main cpu address map with byte-address bases; each window must be aligned to its own size
package arcade_bus_pkg;

    localparam int addr_w      = 23;           // word address, bits 23:1
    localparam int data_w      = 16;
    localparam int byte_addr_w = addr_w + 1;
    localparam int mem_off_w   = 13;           // word offset inside a memory region

    typedef enum logic [2:0] {
        region_none,
        region_sysram,
        region_pal0,
        region_pal1,
        region_disp_f,
        region_disp_b,
        region_disp_c,
        region_io
    } mem_region_e;

    // display layers sit back to back from disp_base, order f, b, c
    localparam logic [byte_addr_w-1:0] disp_base       = 24'h240000;
    localparam logic [byte_addr_w-1:0] disp_layer_size = 24'h002000;
    localparam int                     disp_layers     = 3;
    localparam int                     disp_win_bits   = 13;

    localparam logic [byte_addr_w-1:0] pal0_base   = 24'h310000;
    localparam logic [byte_addr_w-1:0] pal1_base   = 24'h314000;
    localparam int                     pal_win_bits = 14;

    localparam logic [byte_addr_w-1:0] sysram_base     = 24'h318000;
    localparam int                     sysram_win_bits = 14;

    localparam logic [byte_addr_w-1:0] io_base     = 24'h30c000;
    localparam int                     io_win_bits = 5;  // 16 word registers

    // display hold-off once a blank shows up
    localparam int disp_hold_cycles = 2;
    localparam int disp_cnt_w       = 2;

endpackage

// File: hdl/arcade_io_pkg.sv
// i/o register map of the main cpu; reads live at offsets 0 to 7 and writes at 8 to 15
package arcade_io_pkg;

    localparam int io_off_w  = 4;
    localparam int io_wr_bit = 3;   // set on the write-only half of the window

    // read side
    localparam logic [io_off_w-1:0] reg_cab0   = 4'd0;
    localparam logic [io_off_w-1:0] reg_cab1   = 4'd1;
    localparam logic [io_off_w-1:0] reg_dip    = 4'd2;
    localparam logic [io_off_w-1:0] reg_mcu_rd = 4'd4;

    // write side
    localparam logic [io_off_w-1:0] reg_prisel   = 4'd8;
    localparam logic [io_off_w-1:0] reg_snd      = 4'd10;
    localparam logic [io_off_w-1:0] reg_mcu_wr   = 4'd11;
    localparam logic [io_off_w-1:0] reg_vint_clr = 4'd12;

    localparam int                   irq_lvl_w      = 3;
    localparam logic [irq_lvl_w-1:0] irq_lvl_vblank = 3'd6;
    localparam logic [irq_lvl_w-1:0] irq_lvl_mcu    = 3'd5;
    localparam logic [irq_lvl_w-1:0] irq_lvl_none   = 3'd0;

    // fixed bits of the second cabinet word
    localparam logic [7:0] cab1_pad_hi = 8'hff;
    localparam logic [1:0] cab1_pad_lo = 2'b11;

    localparam logic [15:0] unmapped_data = 16'hffff;

endpackage

// File: hdl/disp_access_gate.sv
// holds display cycles until a blank; once started the count runs on even if the blank ends
`timescale 1ns/1ps

module disp_access_gate (
    input  logic clk,
    input  logic rst,
    input  logic disp_req,
    input  logic lvbl,
    input  logic lhbl,
    output logic disp_ready
);
    import arcade_bus_pkg::*;

    logic                  blank;
    logic [disp_cnt_w-1:0] cnt;

    assign blank = !lvbl || !lhbl;   // either blank opens the window

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt        <= '0;
            disp_ready <= 1'b0;
        end else if (!disp_req) begin
            // dropped or finished request starts over
            cnt        <= '0;
            disp_ready <= 1'b0;
        end else if (!disp_ready && (cnt != '0 || blank)) begin
            cnt <= cnt + 1'b1;
            if (cnt == disp_cnt_w'(disp_hold_cycles - 1))
                disp_ready <= 1'b1;
        end
    end

endmodule

// File: hdl/irq_priority.sv
// sticky vblank and mcu requests; a clear in the same cycle as a new edge wins
`timescale 1ns/1ps

module irq_priority (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                lvbl,
    input  logic                                mcu_req,
    input  logic                                vint_clr,
    input  logic                                mcu_ack,
    output logic [arcade_io_pkg::irq_lvl_w-1:0] irq_level
);
    import arcade_io_pkg::*;

    logic lvbl_l;
    logic mcu_req_l;
    logic vint;
    logic mcu_irq;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;   // no false falling edge out of reset
            mcu_req_l <= 1'b1;   // nor a false rising one
            vint      <= 1'b0;
            mcu_irq   <= 1'b0;
        end else begin
            lvbl_l    <= lvbl;
            mcu_req_l <= mcu_req;

            if (vint_clr)
                vint <= 1'b0;
            else if (!lvbl && lvbl_l)
                vint <= 1'b1;

            if (mcu_ack)
                mcu_irq <= 1'b0;   // read of the mailbox acknowledges
            else if (mcu_req && !mcu_req_l)
                mcu_irq <= 1'b1;
        end
    end

    always_comb begin
        if (vint)
            irq_level = irq_lvl_vblank;
        else if (mcu_irq)
            irq_level = irq_lvl_mcu;
        else
            irq_level = irq_lvl_none;
    end

    // clear beats a vblank edge in the same cycle
    a_vint_clr_wins: assert property (@(posedge clk) disable iff (rst)
        vint_clr |=> irq_level != irq_lvl_vblank)
        else $error("vblank level still pending after vint_clr");

endmodule

// File: hdl/main_addr_decode.sv
// purely combinational decode; adr is a word address and region_none covers every unmapped cycle
`timescale 1ns/1ps

module main_addr_decode (
    input  logic [arcade_bus_pkg::addr_w-1:0]  adr,
    input  logic                               we,
    output arcade_bus_pkg::mem_region_e        region,
    output logic [arcade_io_pkg::io_off_w-1:0] io_off
);
    import arcade_bus_pkg::*;
    import arcade_io_pkg::*;

    logic [byte_addr_w-1:0] byte_addr;
    logic                   in_disp_window;

    // same upper bits as the window base
    function automatic logic win_hit(
        input logic [byte_addr_w-1:0] a,
        input logic [byte_addr_w-1:0] base,
        input int                     bits
    );
        return (a >> bits) == (base >> bits);
    endfunction

    assign byte_addr = {adr, 1'b0};
    assign io_off    = adr[io_off_w-1:0];

    always_comb begin
        region = region_none;
        if (win_hit(byte_addr, disp_base, disp_win_bits)) begin
            region = region_disp_f;
        end else if (win_hit(byte_addr, disp_base + disp_layer_size, disp_win_bits)) begin
            region = region_disp_b;
        end else if (win_hit(byte_addr, disp_base + 2 * disp_layer_size, disp_win_bits)) begin
            region = region_disp_c;
        end else if (win_hit(byte_addr, pal0_base, pal_win_bits)) begin
            region = region_pal0;
        end else if (win_hit(byte_addr, pal1_base, pal_win_bits)) begin
            region = region_pal1;
        end else if (win_hit(byte_addr, sysram_base, sysram_win_bits)) begin
            region = region_sysram;
        end else if (win_hit(byte_addr, io_base, io_win_bits)) begin
            // reads only below 8, writes only from 8 up
            if (we == io_off[io_wr_bit])
                region = region_io;
        end

        // independent range check of the whole display block
        in_disp_window = (byte_addr >= disp_base) &&
                         (byte_addr < disp_base + disp_layers * disp_layer_size);

        assert (!(region inside {region_disp_f, region_disp_b, region_disp_c}) ||
                in_disp_window)
            else $error("display region decoded outside display window, adr %h", byte_addr);
    end

endmodule

// File: hdl/main_bus_top.sv
// wishbone classic slave for the main cpu; one cycle in flight and no aborts while waiting
`timescale 1ns/1ps

module main_bus_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  logic [arcade_bus_pkg::addr_w-1:0]    adr,
    input  logic [arcade_bus_pkg::data_w-1:0]    dat_w,
    input  logic [1:0]                           sel,
    output logic [arcade_bus_pkg::data_w-1:0]    dat_r,
    output logic                                 ack,
    input  logic                                 lvbl,
    input  logic                                 lhbl,
    input  logic                                 mcu_req,
    input  logic [15:0]                          mcu_dout,
    output logic [15:0]                          mcu_din,
    output logic                                 mcu_wr,
    output logic [7:0]                           snd_latch,
    output logic                                 snd_irq,
    input  logic [7:0]                           joystick1,
    input  logic [7:0]                           joystick2,
    input  logic [1:0]                           start_button,
    input  logic [1:0]                           coin_input,
    input  logic                                 service,
    input  logic [7:0]                           dipsw_a,
    input  logic [7:0]                           dipsw_b,
    output logic [2:0]                           prisel,
    output logic                                 mem_cs,
    output arcade_bus_pkg::mem_region_e          mem_region,
    output logic [arcade_bus_pkg::mem_off_w-1:0] mem_addr,
    input  logic [arcade_bus_pkg::data_w-1:0]    mem_dout,
    input  logic                                 mem_ok,
    output logic [arcade_io_pkg::irq_lvl_w-1:0]  irq_level
);
    import arcade_bus_pkg::*;
    import arcade_io_pkg::*;

    typedef enum logic [1:0] {st_idle, st_mem, st_disp} ack_state_e;
    typedef enum logic [1:0] {src_ones, src_regs, src_mem} rd_src_e;

    ack_state_e            state;
    rd_src_e               rd_src;
    mem_region_e           region;
    logic [io_off_w-1:0]   io_off;
    logic                  access;
    logic                  wr_stb;
    logic                  rd_stb;
    logic [data_w-1:0]     regs_data;
    logic [data_w-1:0]     mem_data;
    logic                  vint_clr;
    logic                  mcu_ack;
    logic                  disp_ready;

    main_addr_decode u_decode (
        .adr    (adr),
        .we     (we),
        .region (region),
        .io_off (io_off)
    );

    // first cycle of a new bus cycle only
    assign access = cyc && stb && !ack && (state == st_idle);
    assign wr_stb = access && (region == region_io) && we && (|sel);
    assign rd_stb = access && (region == region_io) && !we;

    sys_ctrl_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wr_stb       (wr_stb),
        .rd_stb       (rd_stb),
        .io_off       (io_off),
        .dat_w        (dat_w),
        .rd_data      (regs_data),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .mcu_dout     (mcu_dout),
        .lvbl         (lvbl),
        .snd_latch    (snd_latch),
        .snd_irq      (snd_irq),
        .mcu_din      (mcu_din),
        .mcu_wr       (mcu_wr),
        .prisel       (prisel),
        .vint_clr     (vint_clr),
        .mcu_ack      (mcu_ack)
    );

    irq_priority u_irq (
        .clk       (clk),
        .rst       (rst),
        .lvbl      (lvbl),
        .mcu_req   (mcu_req),
        .vint_clr  (vint_clr),
        .mcu_ack   (mcu_ack),
        .irq_level (irq_level)
    );

    disp_access_gate u_gate (
        .clk        (clk),
        .rst        (rst),
        .disp_req   (state == st_disp),
        .lvbl       (lvbl),
        .lhbl       (lhbl),
        .disp_ready (disp_ready)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            ack        <= 1'b0;
            mem_cs     <= 1'b0;
            mem_region <= region_none;
            rd_src     <= src_ones;
        end else begin
            ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (access) begin
                        case (region)
                            region_io: begin
                                ack    <= 1'b1;
                                rd_src <= src_regs;
                            end
                            region_none: begin
                                ack    <= 1'b1;   // unmapped reads as all ones
                                rd_src <= src_ones;
                            end
                            region_disp_f, region_disp_b, region_disp_c: begin
                                mem_region <= region;
                                state      <= st_disp;
                            end
                            default: begin
                                mem_region <= region;
                                mem_cs     <= 1'b1;
                                state      <= st_mem;
                            end
                        endcase
                    end
                end
                st_disp: begin
                    if (disp_ready) begin   // blank reached
                        mem_cs <= 1'b1;
                        state  <= st_mem;
                    end
                end
                st_mem: begin
                    if (mem_ok) begin
                        mem_cs <= 1'b0;
                        ack    <= 1'b1;
                        rd_src <= src_mem;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            mem_addr <= adr[mem_off_w-1:0];
        if (state == st_mem && mem_ok)
            mem_data <= mem_dout;
    end

    always_comb begin
        case (rd_src)
            src_regs: dat_r = regs_data;
            src_mem:  dat_r = mem_data;
            default:  dat_r = unmapped_data;
        endcase
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held high for more than one cycle");

    // display memory only opens after the gate has seen a blank
    a_disp_after_ready: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_cs) && (mem_region inside {region_disp_f, region_disp_b, region_disp_c})
        |-> $past(disp_ready))
        else $error("display access issued without disp_ready");

endmodule

// File: hdl/sys_ctrl_regs.sv
// register block of the i/o window; wr_stb and rd_stb must be single-cycle and already decoded
`timescale 1ns/1ps

module sys_ctrl_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wr_stb,
    input  logic                               rd_stb,
    input  logic [arcade_io_pkg::io_off_w-1:0] io_off,
    input  logic [arcade_bus_pkg::data_w-1:0]  dat_w,
    output logic [arcade_bus_pkg::data_w-1:0]  rd_data,
    input  logic [7:0]                         joystick1,
    input  logic [7:0]                         joystick2,
    input  logic [1:0]                         start_button,
    input  logic [1:0]                         coin_input,
    input  logic                               service,
    input  logic [7:0]                         dipsw_a,
    input  logic [7:0]                         dipsw_b,
    input  logic [15:0]                        mcu_dout,
    input  logic                               lvbl,
    output logic [7:0]                         snd_latch,
    output logic                               snd_irq,
    output logic [15:0]                        mcu_din,
    output logic                               mcu_wr,
    output logic [2:0]                         prisel,
    output logic                               vint_clr,
    output logic                               mcu_ack
);
    import arcade_io_pkg::*;

    // acknowledge strobes act on the same edge as the bus ack
    assign vint_clr = wr_stb && (io_off == reg_vint_clr);
    assign mcu_ack  = rd_stb && (io_off == reg_mcu_rd);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
            snd_irq   <= 1'b0;
            mcu_din   <= '0;
            mcu_wr    <= 1'b0;
            prisel    <= '0;
        end else begin
            snd_irq <= wr_stb && (io_off == reg_snd);
            mcu_wr  <= wr_stb && (io_off == reg_mcu_wr);
            if (wr_stb) begin
                case (io_off)
                    reg_prisel: prisel    <= dat_w[2:0];
                    reg_snd:    snd_latch <= dat_w[7:0];
                    reg_mcu_wr: mcu_din   <= dat_w;
                    default: ;
                endcase
            end
        end
    end

    // read word held for the ack cycle
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            case (io_off)
                reg_cab0:   rd_data <= {joystick2, joystick1};
                reg_cab1:   rd_data <= {cab1_pad_hi, ~lvbl, service, coin_input,
                                        start_button, cab1_pad_lo};
                reg_dip:    rd_data <= {dipsw_b, dipsw_a};
                reg_mcu_rd: rd_data <= mcu_dout;
                default:    rd_data <= unmapped_data;   // unused read slots
            endcase
        end
    end

endmodule

// File: project.f
+incdir+dv
hdl/arcade_bus_pkg.sv
hdl/arcade_io_pkg.sv
hdl/main_addr_decode.sv
hdl/irq_priority.sv
hdl/sys_ctrl_regs.sv
hdl/disp_access_gate.sv
hdl/main_bus_top.sv
dv/main_bus_tb.sv
